// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= build.f
TB_TOP     ?= uart_tb
RTL_TOP    ?= uart_top
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

# Pass only when the testbench prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
hw/uart_pkg.sv
hw/uart_cfg_regs.sv
hw/uart_core.sv
hw/uart_tx_buffer.sv
hw/uart_rx_buffer.sv
hw/uart_top.sv
verif/uart_tb.sv

// File: hw/uart_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cfg_regs import uart_pkg::*; #(
	parameter baud_div_t RESET_BAUD_DIV = 8'd16
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      cfg_wr,     // Write strobe
	input  reg_addr_t cfg_addr,
	input  reg_data_t cfg_wdata,
	output reg_data_t cfg_rdata,  // Combinational readback
	input  uart_evt_t evt,        // Event pulses to count
	output uart_cfg_t cfg
);

	baud_div_t baud_div_q;
	logic      loopback_q;
	err_cnt_t  ferr_cnt;
	err_cnt_t  ovrn_cnt;

	// ------------------------------------------------------------------------
	// Writable configuration
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			baud_div_q <= RESET_BAUD_DIV;
			loopback_q <= 1'b0;
		end else if (cfg_wr) begin
			if (cfg_addr == REG_BAUD)
				baud_div_q <= cfg_wdata;
			if (cfg_addr == REG_CTRL)
				loopback_q <= cfg_wdata[0]; // Only bit 0 is implemented
		end
	end

	// ------------------------------------------------------------------------
	// Event counters, saturate at all ones
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ferr_cnt <= '0;
			ovrn_cnt <= '0;
		end else begin
			// Clear has priority over a same-cycle event
			if (cfg_wr && cfg_addr == REG_FERR)
				ferr_cnt <= '0;
			else if (evt.frame_err && ferr_cnt != '1)
				ferr_cnt <= ferr_cnt + 8'd1;

			if (cfg_wr && cfg_addr == REG_OVRN)
				ovrn_cnt <= '0;
			else if (evt.overrun && ovrn_cnt != '1)
				ovrn_cnt <= ovrn_cnt + 8'd1;
		end
	end

	// Read mux
	always_comb begin
		case (cfg_addr)
			REG_BAUD: cfg_rdata = baud_div_q;
			REG_CTRL: cfg_rdata = {7'd0, loopback_q};
			REG_FERR: cfg_rdata = ferr_cnt;
			default:  cfg_rdata = ovrn_cnt; // REG_OVRN
		endcase
	end

	assign cfg.baud_div = baud_div_q;
	assign cfg.loopback = loopback_q;

endmodule

`default_nettype wire

// File: hw/uart_core.sv
`timescale 1ns/1ps
`default_nettype none

module uart_core import uart_pkg::*; #(
	parameter int SYNC_STAGES = 3
) (
	input  logic      clk,
	input  logic      rst,
	input  uart_cfg_t cfg,
	input  logic      serial_in,      // Line into the receiver
	output logic      tx_out,         // Idle high
	input  logic      tx_fifo_valid,
	input  byte_t     tx_fifo_byte,
	output logic      tx_load,        // Takes the FIFO head
	output logic      rx_strobe,      // One cycle per good byte
	output byte_t     rx_strobe_byte,
	output logic      frame_err       // One cycle per bad stop bit
);

	// ------------------------------------------------------------------------
	// Transmitter
	// ------------------------------------------------------------------------
	logic      tx_empty;
	baud_div_t tx_cnt;    // Clock within current bit
	logic [3:0] tx_bit;   // 0 start, 1..8 data, 9 stop
	byte_t     tx_shift;
	logic      tx_bit_end;

	assign tx_bit_end = (tx_cnt == cfg.baud_div - 8'd1);
	assign tx_load    = tx_empty & tx_fifo_valid; // Reload only when empty

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tx_empty <= 1'b1;
			tx_out   <= 1'b1;
			tx_cnt   <= '0;
			tx_bit   <= '0;
		end else if (tx_load) begin
			tx_empty <= 1'b0;
			tx_out   <= 1'b0; // Start bit on the next clock
			tx_cnt   <= '0;
			tx_bit   <= '0;
		end else if (!tx_empty) begin
			if (tx_bit_end) begin
				tx_cnt <= '0;
				tx_bit <= tx_bit + 4'd1;
				if (tx_bit < 4'd8)
					tx_out <= tx_shift[0]; // LSB first
				else if (tx_bit == 4'd8)
					tx_out <= 1'b1;        // Stop bit
				else
					tx_empty <= 1'b1;      // Stop bit done
			end else begin
				tx_cnt <= tx_cnt + 8'd1;
			end
		end
	end

	// Data shifter
	always_ff @(posedge clk) begin
		if (tx_load)
			tx_shift <= tx_fifo_byte;
		else if (!tx_empty && tx_bit_end && tx_bit < 4'd8)
			tx_shift <= {1'b0, tx_shift[7:1]};
	end

	// ------------------------------------------------------------------------
	// Receiver
	// ------------------------------------------------------------------------
	logic [SYNC_STAGES-1:0] rx_sync;
	logic       rx_line;      // Synchronized line
	rx_state_e  rx_state;
	baud_div_t  rx_cnt;       // Clock within current bit
	logic [3:0] rx_bit;       // 0 start, 1..8 data
	byte_t      rx_shift;
	logic       rx_mid;       // Mid-bit sample point
	logic       rx_take_bit;
	logic       rx_good_stop;

	assign rx_line      = rx_sync[SYNC_STAGES-1];
	assign rx_mid       = (rx_cnt == (cfg.baud_div >> 1));
	assign rx_take_bit  = (rx_state == RX_DATA) && rx_mid && (rx_bit != 4'd0);
	assign rx_good_stop = (rx_state == RX_STOP) && rx_mid && rx_line;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rx_sync   <= '1; // Line idles high
			rx_state  <= RX_IDLE;
			rx_cnt    <= '0;
			rx_bit    <= '0;
			rx_strobe <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			rx_sync   <= {rx_sync[SYNC_STAGES-2:0], serial_in};
			rx_strobe <= 1'b0;
			frame_err <= 1'b0;

			// Bit timer runs only inside a frame
			if (rx_state == RX_DATA || rx_state == RX_STOP)
				rx_cnt <= (rx_cnt == cfg.baud_div - 8'd1) ? '0 : rx_cnt + 8'd1;

			case (rx_state)
				RX_IDLE: begin
					if (!rx_line) begin // Falling edge seen
						rx_state <= RX_DATA;
						rx_cnt   <= 8'd1;
						rx_bit   <= '0;
					end
				end
				RX_DATA: begin
					if (rx_mid) begin
						if (rx_bit == 4'd0 && rx_line) begin
							rx_state <= RX_IDLE; // Glitch rather than a start bit
						end else begin
							rx_bit <= rx_bit + 4'd1;
							if (rx_bit == 4'd8)
								rx_state <= RX_STOP;
						end
					end
				end
				RX_STOP: begin
					if (rx_mid) begin
						if (rx_line) begin
							rx_strobe <= 1'b1;
							rx_state  <= RX_IDLE;
						end else begin
							frame_err <= 1'b1; // Byte dropped
							rx_state  <= RX_WAIT_IDLE;
						end
					end
				end
				default: begin // RX_WAIT_IDLE
					if (rx_line)
						rx_state <= RX_IDLE;
				end
			endcase
		end
	end

	// Data capture
	always_ff @(posedge clk) begin
		if (rx_take_bit)
			rx_shift <= {rx_line, rx_shift[7:1]}; // LSB arrives first
		if (rx_good_stop)
			rx_strobe_byte <= rx_shift;
	end

endmodule

`default_nettype wire

// File: hw/uart_pkg.sv
`default_nettype none

package uart_pkg;

	// ------------------------------------------------------------------------
	// Vector types
	// ------------------------------------------------------------------------
	typedef logic [7:0] byte_t;      // One data byte
	typedef logic [7:0] baud_div_t;  // Clocks per bit, 4 to 255
	typedef logic [1:0] reg_addr_t;  // Register address
	typedef logic [7:0] reg_data_t;  // Register read/write data
	typedef logic [7:0] err_cnt_t;   // Saturating event count

	// Register map
	localparam reg_addr_t REG_BAUD = 2'd0; // Divisor, read/write
	localparam reg_addr_t REG_CTRL = 2'd1; // Bit 0 loopback
	localparam reg_addr_t REG_FERR = 2'd2; // Framing errors, write clears
	localparam reg_addr_t REG_OVRN = 2'd3; // Receive overruns, write clears

	// Receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE,      // Line idle, looking for a start bit
		RX_DATA,      // Start check and eight data samples
		RX_STOP,      // Stop bit sample
		RX_WAIT_IDLE  // Bad stop bit, hold until line high
	} rx_state_e;

	// Configuration from the register block
	typedef struct packed {
		baud_div_t baud_div;
		logic      loopback;
	} uart_cfg_t;

	// Single-cycle event pulses into the counters
	typedef struct packed {
		logic frame_err;
		logic overrun;
	} uart_evt_t;

endpackage

`default_nettype wire

// File: hw/uart_rx_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_buffer import uart_pkg::*; #(
	parameter int RX_DEPTH = 4 // Power of two
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  rx_strobe,      // Byte from the core
	input  byte_t rx_strobe_byte,
	input  logic  rx_credit,      // Host grants one byte
	output logic  rx_valid,       // One cycle per released byte
	output byte_t rx_byte,
	output logic  overrun         // Strobe lost to a full FIFO
);

	localparam int PTR_W = $clog2(RX_DEPTH);

	byte_t            mem [RX_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic [7:0]       credits;  // Outstanding host grants
	logic             full;
	logic             push;
	logic             pop;

	assign full = (count == RX_DEPTH[PTR_W:0]);
	assign push = rx_strobe & ~full;                   // Full drops the new byte
	assign pop  = (count != '0) && (credits != 8'd0); // Release only against a credit

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= rx_strobe_byte;
	end

	// ------------------------------------------------------------------------
	// Pointers, occupancy and credits
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credits  <= '0;   // Host starts with nothing granted
			rx_valid <= 1'b0;
			rx_byte  <= '0;
			overrun  <= 1'b0;
		end else begin
			rx_valid <= pop;
			overrun  <= rx_strobe & full;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop) begin
				rx_byte <= mem[rd_ptr];
				rd_ptr  <= rd_ptr + 1'b1;
			end
			count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
			// Grant and spend in one cycle cancel
			credits <= credits + {7'd0, rx_credit} - {7'd0, pop};
		end
	end

endmodule

`default_nettype wire

// File: hw/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top import uart_pkg::*; #(
	parameter int        TX_DEPTH       = 4,
	parameter int        RX_DEPTH       = 4,
	parameter int        SYNC_STAGES    = 3,
	parameter baud_div_t RESET_BAUD_DIV = 8'd16
) (
	input  logic      clk,
	input  logic      rst,
	// Serial lines
	input  logic      rx_in,
	output logic      tx_out,
	// Host transmit
	input  logic      tx_valid,
	input  byte_t     tx_byte,
	output logic      tx_credit,
	// Host receive
	input  logic      rx_credit,
	output logic      rx_valid,
	output byte_t     rx_byte,
	// Register port
	input  logic      cfg_wr,
	input  reg_addr_t cfg_addr,
	input  reg_data_t cfg_wdata,
	output reg_data_t cfg_rdata
);

	uart_cfg_t cfg;
	uart_evt_t evt;
	logic      serial_in;
	logic      tx_fifo_valid;
	byte_t     tx_fifo_byte;
	logic      tx_load;
	logic      rx_strobe;
	byte_t     rx_strobe_byte;
	logic      frame_err;
	logic      overrun;

	assign serial_in = cfg.loopback ? tx_out : rx_in; // Loopback mux
	assign evt = '{frame_err: frame_err, overrun: overrun};

	// ------------------------------------------------------------------------
	// Blocks
	// ------------------------------------------------------------------------
	uart_cfg_regs #(.RESET_BAUD_DIV(RESET_BAUD_DIV)) i_regs (
		.clk, .rst, .cfg_wr, .cfg_addr, .cfg_wdata, .cfg_rdata, .evt, .cfg
	);

	uart_core #(.SYNC_STAGES(SYNC_STAGES)) i_core (
		.clk, .rst, .cfg, .serial_in, .tx_out, .tx_fifo_valid, .tx_fifo_byte,
		.tx_load, .rx_strobe, .rx_strobe_byte, .frame_err
	);

	uart_tx_buffer #(.TX_DEPTH(TX_DEPTH)) i_tx_buf (
		.clk, .rst, .tx_valid, .tx_byte, .tx_fifo_valid, .tx_fifo_byte,
		.tx_load, .tx_credit
	);

	uart_rx_buffer #(.RX_DEPTH(RX_DEPTH)) i_rx_buf (
		.clk, .rst, .rx_strobe, .rx_strobe_byte, .rx_credit, .rx_valid,
		.rx_byte, .overrun
	);

endmodule

`default_nettype wire

// File: hw/uart_tx_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_buffer import uart_pkg::*; #(
	parameter int TX_DEPTH = 4 // Power of two
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  tx_valid,      // Host push, always backed by a credit
	input  byte_t tx_byte,
	output logic  tx_fifo_valid, // Head available to the core
	output byte_t tx_fifo_byte,
	input  logic  tx_load,       // Core pop
	output logic  tx_credit      // One credit back per pop
);

	localparam int PTR_W = $clog2(TX_DEPTH);

	byte_t            mem [TX_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;   // One extra bit for full

	// ------------------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (tx_valid)
			mem[wr_ptr] <= tx_byte;
	end

	// Pointers wrap naturally at a power of two
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (tx_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (tx_load)
				rd_ptr <= rd_ptr + 1'b1;
			case ({tx_valid, tx_load})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // Both or neither
			endcase
		end
	end

	assign tx_fifo_valid = (count != '0);
	assign tx_fifo_byte  = mem[rd_ptr];

	// Credit returns with the pop, same cycle
	assign tx_credit = tx_load;

endmodule

`default_nettype wire

// File: verif/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb import uart_pkg::*; ();

	localparam int        TX_DEPTH    = 4;
	localparam int        RX_DEPTH    = 4;
	localparam baud_div_t RESET_DIV   = 8'd16;
	localparam int        MAX_DIV     = 16;                          // Largest divisor used
	localparam int        NUM_FRAMES  = 2 + TX_DEPTH + 2 + RX_DEPTH + 1;
	localparam int        CYCLE_LIMIT = NUM_FRAMES * 10 * MAX_DIV + 1000;
	localparam int        WAIT_LIMIT  = 12 * MAX_DIV * TX_DEPTH;    // Per-handshake bound

	logic      clk = 1'b0;
	logic      rst;
	logic      rx_in;
	logic      tx_out;
	logic      tx_valid;
	logic      tx_credit;
	logic      rx_credit;
	logic      rx_valid;
	logic      cfg_wr;
	byte_t     tx_byte;
	byte_t     rx_byte;
	reg_addr_t cfg_addr;
	reg_data_t cfg_wdata;
	reg_data_t cfg_rdata;

	logic [31:0] lcg_state = 32'h87c79ab5;
	int          errors, test_errs, pass_cnt, fail_cnt, cycles;
	int          host_credits = TX_DEPTH; // Transmit credits in host hands
	int          rx_grants;               // Receive credits granted and not yet used
	int          rx_count;
	int          credit_pulses;
	byte_t       rx_exp;
	byte_t       exp_q[$];                // Due at rx_valid in order
	byte_t       line_q[$];               // Due on tx_out in order

	uart_top #(.TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH), .SYNC_STAGES(3),
		.RESET_BAUD_DIV(RESET_DIV)) i_dut (.*);

	always #2 clk = ~clk;

	// Run-length guard
	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles, a test is stuck", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Host side of both credit loops
	// ------------------------------------------------------------------------
	always @(negedge clk) begin
		if (tx_credit) begin
			host_credits++;
			credit_pulses++;
		end
		if (rx_valid) begin
			assert (rx_grants > 0) else report_error("rx_valid with no credit granted");
			rx_grants--;
			rx_count++;
			if (exp_q.size() == 0) begin
				report_error($sformatf("Unexpected byte %02h", rx_byte));
			end else begin
				rx_exp = exp_q.pop_front();
				assert (rx_byte == rx_exp) else
					report_error($sformatf("rx_byte %02h, expected %02h", rx_byte, rx_exp));
			end
		end
	end

	function automatic byte_t rand_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223; // Numerical Recipes LCG
		return lcg_state[23:16];
	endfunction

	task automatic report_error(input string msg);
		$display("** Error: %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic note_failure(input string msg);
		$display("Failure at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name);
		if (errors == test_errs) begin
			pass_cnt++;
			$display("Test %s passed", name);
		end else begin
			fail_cnt++;
			$display("Test %s failed with %0d errors", name, errors - test_errs);
		end
		test_errs = errors;
	endtask

	task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
		@(negedge clk);
		cfg_wr    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		@(negedge clk);
		cfg_wr    = 1'b0;
	endtask

	task automatic check_reg(input reg_addr_t addr, input reg_data_t exp);
		@(negedge clk);
		cfg_addr = addr;
		#1; // Combinational read settles
		assert (cfg_rdata == exp) else
			report_error($sformatf("Reg %0d reads %02h, expected %02h", addr, cfg_rdata, exp));
	endtask

	// One byte per cycle against host credits
	task automatic push_bytes(input int n, input bit to_rx);
		byte_t b;
		repeat (n) begin
			@(negedge clk);
			assert (host_credits > 0) else note_failure("Host push without a credit");
			b = rand_byte();
			tx_valid = 1'b1;
			tx_byte  = b;
			host_credits--;
			if (to_rx)
				exp_q.push_back(b);
			else
				line_q.push_back(b);
		end
		@(negedge clk);
		tx_valid = 1'b0;
	endtask

	task automatic grant_credits(input int n);
		repeat (n) begin
			@(negedge clk);
			rx_credit = 1'b1;
			rx_grants++;
		end
		@(negedge clk);
		rx_credit = 1'b0;
	endtask

	task automatic wait_rx(input int target);
		int n = 0;
		while (rx_count < target && n < WAIT_LIMIT) begin
			@(posedge clk); // rx_count moves only on the falling edge
			n++;
		end
		assert (rx_count >= target) else note_failure("No rx_valid within the wait limit");
		@(negedge clk);
	endtask

	// ------------------------------------------------------------------------
	// Serial line models
	// ------------------------------------------------------------------------
	task automatic send_frame(input byte_t b, input logic stop, input int div);
		logic [9:0] bits;
		bits = {stop, b, 1'b0}; // Start bit goes out first
		@(negedge clk);
		for (int i = 0; i < 10; i++) begin
			rx_in = bits[i];
			repeat (div) @(negedge clk);
		end
		rx_in = 1'b1;
		repeat (div) @(negedge clk); // Idle gap
	endtask

	task automatic catch_frame(input int div, output byte_t b);
		int n = 0;
		b = 8'h00;
		while (tx_out && n < 20 * div) begin
			@(negedge clk);
			n++;
		end
		assert (!tx_out) else note_failure("No start bit seen on tx_out");
		repeat (div / 2) @(negedge clk); // To mid-bit
		assert (!tx_out) else report_error("Start bit not low at mid-bit");
		for (int i = 0; i < 8; i++) begin
			repeat (div) @(negedge clk);
			b[i] = tx_out;            // LSB first
		end
		repeat (div) @(negedge clk);
		assert (tx_out) else report_error("Stop bit not high");
	endtask

	initial begin
		byte_t b;
		byte_t exp;
		int    base;
		rst       = 1'b1;
		rx_in     = 1'b1;
		tx_valid  = 1'b0;
		tx_byte   = 8'h00;
		rx_credit = 1'b0;
		cfg_wr    = 1'b0;
		cfg_addr  = REG_BAUD;
		cfg_wdata = 8'h00;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		// Reset values
		@(negedge clk);
		assert (tx_out && !tx_credit && !rx_valid && rx_byte == 8'h00) else
			report_error("Outputs not at reset values");
		check_reg(REG_BAUD, RESET_DIV);
		check_reg(REG_CTRL, 8'h00);
		check_reg(REG_FERR, 8'h00);
		check_reg(REG_OVRN, 8'h00);
		finish_test("reset");

		// Line format over two back-to-back frames
		reg_write(REG_BAUD, 8'd8);
		check_reg(REG_BAUD, 8'd8);
		base = credit_pulses;
		push_bytes(2, 1'b0);
		repeat (2) begin
			catch_frame(8, b);
			exp = line_q.pop_front();
			assert (b == exp) else report_error($sformatf("tx_out %02h, expected %02h", b, exp));
		end
		assert (credit_pulses - base == 2 && host_credits == TX_DEPTH) else
			report_error($sformatf("%0d tx_credit pulses for 2 bytes", credit_pulses - base));
		finish_test("tx_format");

		// Loopback with receive credits handed out one at a time
		reg_write(REG_BAUD, 8'd12);
		reg_write(REG_CTRL, 8'h01);
		check_reg(REG_CTRL, 8'h01);
		push_bytes(TX_DEPTH, 1'b1);
		base = rx_count;
		for (int i = 1; i <= TX_DEPTH; i++) begin
			grant_credits(1);
			wait_rx(base + i);
		end
		assert (exp_q.size() == 0 && host_credits == TX_DEPTH) else
			report_error("Loopback bytes or transmit credits missing");
		reg_write(REG_CTRL, 8'h00);
		finish_test("loopback");

		// Bad stop bit then a clean frame
		reg_write(REG_BAUD, 8'd16);
		grant_credits(1);
		base = rx_count;
		send_frame(rand_byte(), 1'b0, 16);
		check_reg(REG_FERR, 8'h01);
		assert (rx_count == base) else report_error("Byte released from a bad frame");
		b = rand_byte();
		exp_q.push_back(b);
		send_frame(b, 1'b1, 16);
		wait_rx(base + 1);
		finish_test("frame_error");

		// One frame too many with no credits
		base = rx_count;
		for (int i = 0; i <= RX_DEPTH; i++) begin
			b = rand_byte();
			if (i < RX_DEPTH)
				exp_q.push_back(b); // Last one meets a full FIFO
			send_frame(b, 1'b1, 16);
		end
		check_reg(REG_OVRN, 8'h01);
		assert (rx_count == base) else report_error("Byte released without a credit");
		grant_credits(RX_DEPTH);
		wait_rx(base + RX_DEPTH);
		assert (exp_q.size() == 0) else report_error("Stored bytes not all released");
		reg_write(REG_OVRN, 8'hA5);
		check_reg(REG_OVRN, 8'h00);
		finish_test("overrun");

		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
